//--- dv/p4_router_echo_tb.sv
// reads dv/router_stimulus.txt relative to the project root
// metadata records are checked in order; the queue model assumes fifo_depth entries
`timescale 1ns/1ps
`default_nettype none

module p4_router_echo_tb
    import p4_router_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    beat_t                 in_beat;
    logic                  in_valid;
    logic                  in_ready;
    beat_t                 out_beat;
    logic                  out_valid;
    logic                  out_ready;
    logic [port_id_w-1:0]  meta_in_port;
    logic                  meta_in_valid;
    meta_t                 meta_out;
    logic                  meta_out_valid;
    logic                  meta_out_ready;

    logic [31:0]           rng_state;    // xorshift state
    int                    n_lines;      // stimulus length, sets the watchdog
    meta_t                 exp_meta[$];  // records expected in the metadata queue

    p4_router_echo_top p4_router_echo_top_inst (.*);

    always #10 clk = ~clk;  // 20 ns period

    ////////////////////////////////////////
    // helpers

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    // one apb transfer, setup then access until pready
    // lkp_first set when a lookup holds the table in the first access cycle
    task automatic apb_check(input logic wr, input logic [apb_addr_w-1:0] addr,
                             input logic [31:0] wdata, input logic chk_rd,
                             input logic [31:0] exp_rd, input logic exp_err,
                             input logic lkp_first);
        int   cycles;
        logic is_tbl;
        is_tbl = addr >= reg_table_base && addr < 12'(reg_table_base + 4 * num_ports)
                 && addr[1:0] == 2'b00;  // mapped table entry
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        cycles  = 1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
            cycles++;
        end
        check("pslverr", 64'(pslverr), 64'(exp_err));
        if (chk_rd) begin
            check("prdata", 64'(prdata), 64'(exp_rd));
        end
        if (exp_err || !is_tbl) begin
            check("apb access cycles", 64'(cycles), 64'd1);  // registers and errors
        end else if (lkp_first) begin
            check("apb table access cycles", 64'(cycles), 64'd3);  // lookup wins first
        end else begin
            check("apb table access cycles", 64'(cycles), 64'd2);  // grant, then data
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // one metadata pulse; drains the queue unless hold is set
    task automatic send_meta(input logic [port_id_w-1:0] port,
                             input logic [port_id_w-1:0] egr, input logic hold);
        meta_t rec;
        logic  was_empty;
        was_empty    = exp_meta.size() == 0;
        rec.ing_port = port;
        rec.egr_spec = egr;
        if (exp_meta.size() < fifo_depth) begin
            exp_meta.push_back(rec);  // else the record is dropped
        end
        meta_in_port  = port;
        meta_in_valid = 1'b1;
        @(negedge clk);
        if (was_empty) begin
            check("meta_out_valid", 64'(meta_out_valid), 64'd0);
        end
        @(posedge clk);
        #2;
        meta_in_valid = 1'b0;
        @(negedge clk);
        if (was_empty) begin
            check("meta_out_valid", 64'(meta_out_valid), 64'd0);
        end
        @(posedge clk);
        #2;
        meta_out_ready = !hold;
        @(negedge clk);
        check("meta_out_valid", 64'(meta_out_valid), 64'd1);  // 2 cycles after pulse
        while (!hold && exp_meta.size() != 0) begin
            rec = exp_meta.pop_front();
            check("meta_out_valid", 64'(meta_out_valid), 64'd1);
            check("meta_out.ing_port", 64'(meta_out.ing_port), 64'(rec.ing_port));
            check("meta_out.egr_spec", 64'(meta_out.egr_spec), 64'(rec.egr_spec));
            @(posedge clk);
            #2;
            @(negedge clk);
        end
        if (!hold) begin
            check("meta_out_valid", 64'(meta_out_valid), 64'd0);  // queue empty
        end
        @(posedge clk);
        #2;
        meta_out_ready = 1'b0;
    endtask

    // packet burst; out_ready drops one cycle in every stall+1
    task automatic run_packet(input int beats, input int stall);
        beat_t ref_q[$];
        beat_t exp;
        int    sent;
        int    rcvd;
        int    cyc;
        logic  took;
        sent = 0;
        rcvd = 0;
        cyc  = 0;
        took = 1'b0;
        while (rcvd < beats) begin
            if (took) begin
                in_valid = 1'b0;
            end
            if (!in_valid && sent < beats) begin
                in_beat.data = {next_rand(), next_rand()};
                in_beat.keep = (sent == beats - 1) ? (8'(next_rand()) | 8'h01) : 8'hff;
                in_beat.last = sent == beats - 1;
                in_valid     = 1'b1;
            end
            out_ready = (stall == 0) || (cyc % (stall + 1) != 0);
            @(negedge clk);
            took = in_valid && in_ready;
            if (took) begin
                ref_q.push_back(in_beat);  // accepted at the next edge
                sent++;
            end
            if (out_valid && out_ready) begin
                if (ref_q.size() == 0) begin
                    abort_run("a beat left the router that was never sent");
                end
                exp = ref_q.pop_front();
                check("out_beat.data", out_beat.data, exp.data);
                check("out_beat.keep", 64'(out_beat.keep), 64'(exp.keep));
                check("out_beat.last", 64'(out_beat.last), 64'(exp.last));
                rcvd++;
            end
            cyc++;
            @(posedge clk);
            #2;
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
    endtask

    ////////////////////////////////////////
    // watchdog

    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 200) @(posedge clk);
        $display("timeout: stimulus did not finish within %0d cycles", n_lines * 200);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////
    // main sequence

    initial begin
        logic [8*8-1:0]   cmd;
        logic [8*128-1:0] line;
        logic [31:0]      a1;
        logic [31:0]      a2;
        int               mode;
        int               fd;
        int               n;
        clk            = 1'b0;
        rst_n          = 1'b0;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        in_beat        = '0;
        in_valid       = 1'b0;
        out_ready      = 1'b1;
        meta_in_port   = '0;
        meta_in_valid  = 1'b0;
        meta_out_ready = 1'b0;
        rng_state      = 32'hd11c_6155;
        n_lines        = 0;
        fd = $fopen("dv/router_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/router_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n_lines++;  // whole file, comments too
        end
        $fclose(fd);
        fd = $fopen("dv/router_stimulus.txt", "r");
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check("out_valid", 64'(out_valid), 64'd0);
        check("meta_out_valid", 64'(meta_out_valid), 64'd0);
        check("pready", 64'(pready), 64'd0);
        check("pslverr", 64'(pslverr), 64'd0);
        check("in_ready", 64'(in_ready), 64'd1);
        @(posedge clk);
        #2;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": n = $fgets(line, fd);  // comment, skip rest of line
                "W": begin
                    n = $fscanf(fd, "%h %h", a1, a2);
                    apb_check(1'b1, 12'(a1), a2, 1'b0, '0, 1'b0, 1'b0);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", a1, a2);
                    apb_check(1'b0, 12'(a1), '0, 1'b1, a2, 1'b0, 1'b0);
                end
                "E": begin
                    n = $fscanf(fd, "%h", a1);
                    apb_check(1'b1, 12'(a1), '1, 1'b0, '0, 1'b1, 1'b0);
                    if (12'(a1) != reg_lookups && 12'(a1) != reg_drops) begin
                        apb_check(1'b0, 12'(a1), '0, 1'b0, '0, 1'b1, 1'b0);  // unmapped read
                    end
                end
                "M": begin
                    n = $fscanf(fd, "%h %h %d", a1, a2, mode);
                    if (mode == 2) begin
                        // table read over apb lands in the lookup's cycle
                        fork
                            apb_check(1'b0, 12'(reg_table_base + 4 * a1), '0, 1'b1, a2,
                                      1'b0, 1'b1);
                            begin
                                @(posedge clk);
                                #2;
                                send_meta(port_id_w'(a1), port_id_w'(a2), 1'b0);
                            end
                        join
                    end else begin
                        send_meta(port_id_w'(a1), port_id_w'(a2), mode == 1);
                    end
                end
                "P": begin
                    n = $fscanf(fd, "%d %d", a1, a2);
                    run_packet(int'(a1), int'(a2));
                end
                default: abort_run("unknown command in the stimulus file");
            endcase
        end
        $fclose(fd);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/router_stimulus.txt
# cmd arg1 arg2 [arg3]; addresses, data, ports and egress in hex, P counts and M mode decimal
# W addr data | R addr exp | E addr | M port egr mode (0 drain, 1 hold, 2 apb read) | P beats stall
R 000 1
R 004 0
R 008 0
R 040 0
R 044 1
R 05c 7
R 07c f
M 3 3 0
M a a 0
M f f 0
P 8 0
P 12 2
W 000 0
W 048 9
W 07c 2
M 2 9 0
M f 2 0
M 1 1 0
R 048 9
W 054 c
M 5 c 2
R 07c 2
P 6 1
M 4 4 1
M 6 6 1
M 7 7 1
M 8 8 1
M 9 9 1
M b b 1
M c c 0
R 004 b
R 008 3
E 004
E 008
E 00c
E 080
E 042
R 004 b
R 008 3
R 000 0
R 040 0
W 000 1
M 9 9 0
R 004 c
R 000 1

//--- flist.f
logic/p4_router_pkg.sv
logic/stream_fifo.sv
logic/port_map_table.sv
logic/table_arbiter.sv
logic/apb_table_regs.sv
logic/egress_lookup.sv
logic/p4_router_echo_top.sv
dv/p4_router_echo_tb.sv

//--- logic/apb_table_regs.sv
// apb slave: ctrl, two read-only counters and the port map window
// register accesses take one access cycle; table accesses wait for the arbiter
`timescale 1ns/1ps
`default_nettype none

module apb_table_regs
    import p4_router_pkg::*;
(
    input  var logic                  clk,
    input  var logic                  rst_n,

    input  var logic [apb_addr_w-1:0] paddr,
    input  var logic                  psel,
    input  var logic                  penable,
    input  var logic                  pwrite,
    input  var logic [apb_data_w-1:0] pwdata,
    output var logic [apb_data_w-1:0] prdata,
    output var logic                  pready,
    output var logic                  pslverr,

    output var logic                  echo_mode,
    input  var logic                  lookup_done,
    input  var logic                  meta_drop,

    output var table_req_t            tbl_req,
    output var logic                  tbl_req_valid,
    input  var logic                  tbl_gnt,
    input  var logic [port_id_w-1:0]  tbl_rdata
);

    logic                  access;       // access phase
    logic                  hit_ctrl;
    logic                  hit_lookups;
    logic                  hit_drops;
    logic                  hit_cnt;
    logic                  hit_table;
    logic                  bad_access;   // unmapped or counter write
    logic                  tbl_done;     // granted last cycle
    logic [apb_data_w-1:0] lookups_q;
    logic [apb_data_w-1:0] drops_q;

    ////////////////////////////////////////
    // address decode

    assign access      = psel && penable;
    assign hit_ctrl    = paddr == reg_ctrl;
    assign hit_lookups = paddr == reg_lookups;
    assign hit_drops   = paddr == reg_drops;
    assign hit_cnt     = hit_lookups || hit_drops;
    assign hit_table   = (paddr[apb_addr_w-1:idx_w+2] == reg_table_base[apb_addr_w-1:idx_w+2])
                         && (paddr[1:0] == 2'b00);  // word aligned only
    assign bad_access  = !(hit_ctrl || hit_cnt || hit_table) || (pwrite && hit_cnt);

    ////////////////////////////////////////
    // table side

    // held through the whole access, the arbiter grants it once
    assign tbl_req_valid = access && hit_table;
    assign tbl_req.wr    = pwrite;
    assign tbl_req.idx   = paddr[idx_w+1:2];
    assign tbl_req.wdata = pwdata[port_id_w-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tbl_done <= 1'b0;
        end else begin
            tbl_done <= tbl_req_valid && tbl_gnt;  // data valid next cycle
        end
    end

    // errors and register hits finish at once, table hits after the answer
    assign pready  = access && (!hit_table || tbl_done);
    assign pslverr = access && bad_access;

    ////////////////////////////////////////
    // registers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            echo_mode <= 1'b1;  // echo by default
            lookups_q <= '0;
            drops_q   <= '0;
        end else begin
            if (access && pwrite && hit_ctrl) begin
                echo_mode <= pwdata[ctrl_echo_bit];
            end
            lookups_q <= lookups_q + apb_data_w'(lookup_done);
            drops_q   <= drops_q + apb_data_w'(meta_drop);
        end
    end

    // read mux, zero for anything unmapped
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[ctrl_echo_bit] = echo_mode;
        end else if (hit_lookups) begin
            prdata = lookups_q;
        end else if (hit_drops) begin
            prdata = drops_q;
        end else if (hit_table) begin
            prdata = apb_data_w'(tbl_rdata);  // zero-extended entry
        end
    end

endmodule

`default_nettype wire

//--- logic/egress_lookup.sv
// metadata path: port in, egress spec out two cycles later through a small queue
// relies on the arbiter granting every lookup read in its first cycle
`timescale 1ns/1ps
`default_nettype none

module egress_lookup
    import p4_router_pkg::*;
(
    input  var logic                 clk,
    input  var logic                 rst_n,

    input  var logic [port_id_w-1:0] meta_in_port,
    input  var logic                 meta_in_valid,
    input  var logic                 echo_mode,

    output var table_req_t           tbl_req,
    output var logic                 tbl_req_valid,
    input  var logic [port_id_w-1:0] tbl_rdata,

    output var meta_t                meta_out,
    output var logic                 meta_out_valid,
    input  var logic                 meta_out_ready,

    output var logic                 lookup_done,
    output var logic                 meta_drop
);

    logic [port_id_w-1:0] port_q;   // ingress port of the pulse
    logic                 valid_q;  // record resolves this cycle
    logic                 echo_q;   // mode seen with the pulse
    meta_t                rec;
    logic                 q_ready;

    // table read issued with the pulse itself
    assign tbl_req_valid = meta_in_valid && !echo_mode;
    assign tbl_req.wr    = 1'b0;
    assign tbl_req.idx   = meta_in_port[idx_w-1:0];
    assign tbl_req.wdata = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= meta_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        port_q <= meta_in_port;
        echo_q <= echo_mode;
    end

    // resolve, then queue
    assign rec.ing_port = port_q;
    assign rec.egr_spec = echo_q ? port_q : tbl_rdata;

    assign lookup_done = valid_q && q_ready;
    assign meta_drop   = valid_q && !q_ready;  // queue full, record lost

    stream_fifo #(
        .payload_t (meta_t)
    ) stream_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (rec),
        .in_valid  (valid_q),
        .in_ready  (q_ready),
        .out_data  (meta_out),
        .out_valid (meta_out_valid),
        .out_ready (meta_out_ready)
    );

endmodule

`default_nettype wire

//--- logic/p4_router_echo_top.sv
// router subsystem top, single clock domain
// meta_in has no ready; pulses arriving on a full metadata queue are counted and lost
`timescale 1ns/1ps
`default_nettype none

module p4_router_echo_top
    import p4_router_pkg::*;
(
    input  var logic                  clk,
    input  var logic                  rst_n,

    // apb control
    input  var logic [apb_addr_w-1:0] paddr,
    input  var logic                  psel,
    input  var logic                  penable,
    input  var logic                  pwrite,
    input  var logic [apb_data_w-1:0] pwdata,
    output var logic [apb_data_w-1:0] prdata,
    output var logic                  pready,
    output var logic                  pslverr,

    // packets
    input  var beat_t                 in_beat,
    input  var logic                  in_valid,
    output var logic                  in_ready,
    output var beat_t                 out_beat,
    output var logic                  out_valid,
    input  var logic                  out_ready,

    // metadata
    input  var logic [port_id_w-1:0]  meta_in_port,
    input  var logic                  meta_in_valid,
    output var meta_t                 meta_out,
    output var logic                  meta_out_valid,
    input  var logic                  meta_out_ready
);

    logic                 echo_mode;
    logic                 lookup_done;
    logic                 meta_drop;
    table_req_t           lkp_req;
    logic                 lkp_req_valid;
    table_req_t           apb_req;
    logic                 apb_req_valid;
    logic                 apb_gnt;
    table_req_t           mem_req;
    logic                 mem_en;
    logic [port_id_w-1:0] tbl_rdata;  // shared by lookup and apb

    ////////////////////////////////////////
    // packet path

    stream_fifo #(
        .payload_t (beat_t)
    ) stream_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    ////////////////////////////////////////
    // metadata path and control

    egress_lookup egress_lookup_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .meta_in_port   (meta_in_port),
        .meta_in_valid  (meta_in_valid),
        .echo_mode      (echo_mode),
        .tbl_req        (lkp_req),
        .tbl_req_valid  (lkp_req_valid),
        .tbl_rdata      (tbl_rdata),
        .meta_out       (meta_out),
        .meta_out_valid (meta_out_valid),
        .meta_out_ready (meta_out_ready),
        .lookup_done    (lookup_done),
        .meta_drop      (meta_drop)
    );

    apb_table_regs apb_table_regs_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .echo_mode     (echo_mode),
        .lookup_done   (lookup_done),
        .meta_drop     (meta_drop),
        .tbl_req       (apb_req),
        .tbl_req_valid (apb_req_valid),
        .tbl_gnt       (apb_gnt),
        .tbl_rdata     (tbl_rdata)
    );

    table_arbiter table_arbiter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .lkp_req       (lkp_req),
        .lkp_req_valid (lkp_req_valid),
        .apb_req       (apb_req),
        .apb_req_valid (apb_req_valid),
        .apb_gnt       (apb_gnt),
        .mem_req       (mem_req),
        .mem_en        (mem_en)
    );

    port_map_table port_map_table_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_en  (mem_en),
        .rdata   (tbl_rdata)
    );

endmodule

`default_nettype wire

//--- logic/p4_router_pkg.sv
// widths, register map and stream types shared by the router blocks
// fifo_depth must be a power of two; table base must sit on a 64-byte boundary
`default_nettype none

package p4_router_pkg;

    ////////////////////////////////////////
    // sizes

    localparam int port_id_w  = 4;                  // ingress id and egress spec
    localparam int num_ports  = 16;                 // port map entries
    localparam int idx_w      = $clog2(num_ports);  // table index bits
    localparam int data_bytes = 8;                  // 64-bit beats
    localparam int fifo_depth = 4;                  // per stream fifo
    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;

    ////////////////////////////////////////
    // register map

    localparam logic [apb_addr_w-1:0] reg_ctrl       = 12'h000;  // bit 0 echo_mode
    localparam logic [apb_addr_w-1:0] reg_lookups    = 12'h004;  // ro, done lookups
    localparam logic [apb_addr_w-1:0] reg_drops      = 12'h008;  // ro, lost records
    localparam logic [apb_addr_w-1:0] reg_table_base = 12'h040;  // entry i at +4*i
    localparam int                    ctrl_echo_bit  = 0;

    ////////////////////////////////////////
    // payload types

    // one packet beat, 73 bits
    typedef struct packed {
        logic [data_bytes*8-1:0] data;
        logic [data_bytes-1:0]   keep;  // byte enables
        logic                    last;  // end of packet
    } beat_t;

    // metadata record, 8 bits
    typedef struct packed {
        logic [port_id_w-1:0] ing_port;
        logic [port_id_w-1:0] egr_spec;
    } meta_t;

    // table access, 9 bits
    typedef struct packed {
        logic                 wr;     // 1 = write
        logic [idx_w-1:0]     idx;    // entry select
        logic [port_id_w-1:0] wdata;  // new egress spec
    } table_req_t;

endpackage

`default_nettype wire

//--- logic/port_map_table.sv
// single-port egress table, reset loads the identity map
// rdata is updated on every enabled access and holds the old entry on a write
`timescale 1ns/1ps
`default_nettype none

module port_map_table
    import p4_router_pkg::*;
(
    input  var logic                 clk,
    input  var logic                 rst_n,

    input  var table_req_t           mem_req,
    input  var logic                 mem_en,
    output var logic [port_id_w-1:0] rdata
);

    logic [port_id_w-1:0] entries [num_ports];  // egress spec per ingress port

    ////////////////////////////////////////
    // entry array

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ports; i++) begin
                entries[i] <= port_id_w'(i);  // entry i maps to port i
            end
        end else if (mem_en && mem_req.wr) begin
            entries[mem_req.idx] <= mem_req.wdata;
        end
    end

    // registered read, one cycle after the access
    always_ff @(posedge clk) begin
        if (mem_en) begin
            rdata <= entries[mem_req.idx];  // read-before-write
        end
    end

endmodule

`default_nettype wire

//--- logic/stream_fifo.sv
// valid/ready fifo; no push while full, even if a pop happens in the same cycle
// out_data comes straight from the storage flops
`timescale 1ns/1ps
`default_nettype none

module stream_fifo
    import p4_router_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  var logic     clk,
    input  var logic     rst_n,

    input  var payload_t in_data,
    input  var logic     in_valid,
    output var logic     in_ready,

    output var payload_t out_data,
    output var logic     out_valid,
    input  var logic     out_ready
);

    localparam int ptr_w = $clog2(fifo_depth);

    payload_t         mem [fifo_depth];  // circular storage
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;             // entries held
    logic             push;
    logic             pop;

    assign in_ready  = count < (ptr_w+1)'(fifo_depth);  // high out of reset
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    ////////////////////////////////////////
    // pointers and fill level

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (ptr_w+1)'(push) - (ptr_w+1)'(pop);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/table_arbiter.sv
// fixed priority, the lookup always owns the table when it asks
// apb requests may starve under back-to-back lookups
`timescale 1ns/1ps
`default_nettype none

module table_arbiter
    import p4_router_pkg::*;
(
    input  var logic       clk,
    input  var logic       rst_n,

    input  var table_req_t lkp_req,
    input  var logic       lkp_req_valid,
    input  var table_req_t apb_req,
    input  var logic       apb_req_valid,
    output var logic       apb_gnt,

    output var table_req_t mem_req,
    output var logic       mem_en
);

    logic apb_owner;  // apb access in flight, its data is on rdata now

    ////////////////////////////////////////
    // grant and steering

    // apb only gets free cycles; its own answer cycle is not granted again
    assign apb_gnt = apb_req_valid && !lkp_req_valid && !apb_owner;

    assign mem_en  = lkp_req_valid || apb_gnt;
    assign mem_req = lkp_req_valid ? lkp_req : apb_req;  // lookup first

    // read owner; shared rdata belongs to apb when set, else to lookup
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            apb_owner <= 1'b0;
        end else begin
            apb_owner <= apb_gnt;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the router testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module p4_router_echo_tb \
    -Mdir obj_dir -o p4_router_echo_tb > build.log 2>&1 \
    && { ./obj_dir/p4_router_echo_tb > "$log" 2>&1; true; } \
    || { echo "build failed, see build.log"; exit 1; }

cat "$log"

grep -q "RESULT: FAIL" "$log" && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" "$log" || { echo "simulation ended without a result"; exit 1; }
exit 0
